// ==== logic/rs_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// widths, vector typedefs and entry count for the reservation station
// integer ALU operation encoding
//////////////////////////////////////////////////////////////////////

package rs_types_pkg;

    // datapath and tag widths
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH = 5;

    // shift amount taken from the low bits of the second source
    localparam int SHAMT_WIDTH = 5;

    // one ALU unit per entry
    localparam int NUM_ENTRIES = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [NUM_ENTRIES-1:0] entry_mask_t;
    typedef logic [$clog2(NUM_ENTRIES)-1:0] entry_idx_t;

    // value already final, no producer to wait for
    localparam tag_t ZERO_TAG = '0;

    //////////////////////////////////////////////////////////////////////
    // alu operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

// ==== logic/rs_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// packed structs carried between the reservation station stages
// operands, dispatch packets, entry payloads and the CDB broadcast
//////////////////////////////////////////////////////////////////////

package rs_bus_pkg;

    import rs_types_pkg::*;

    // one source operand, 38 bits
    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  ready;
    } operand_t;

    //////////////////////////////////////////////////////////////////////
    // dispatch side
    //////////////////////////////////////////////////////////////////////

    // src[0] is the first source, src[1] the second (shift amount source)
    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        operand_t [1:0]     src;
        tag_t               dest;
    } dispatch_packet_t;

    // payload held by one entry while it waits and executes
    typedef struct packed {
        alu_op_e            op;
        operand_t [1:0]     src;
        tag_t               dest;
    } rs_entry_t;

    //////////////////////////////////////////////////////////////////////
    // broadcast side
    //////////////////////////////////////////////////////////////////////

    // one result per cycle, qualified by valid
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_packet_t;

endpackage

// ==== logic/rs_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// dispatch stage: operand capture with same-cycle CDB bypass
// and lowest-index free entry selection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_dispatch (
    input  logic                           clock,
    input  logic                           reset,
    input  rs_bus_pkg::dispatch_packet_t   dispatch,
    input  rs_bus_pkg::cdb_packet_t        cdb,
    input  rs_types_pkg::entry_mask_t      busy,
    input  rs_types_pkg::entry_mask_t      grant,
    output rs_bus_pkg::rs_entry_t          new_entry,
    output logic                           new_valid,
    output rs_types_pkg::entry_idx_t       new_idx
);

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    entry_mask_t free;
    logic        found;

    // zero tag is final, otherwise try to catch the broadcast this cycle
    function automatic operand_t capture(operand_t src, cdb_packet_t bus);
        operand_t op;
        op = src;
        if (src.tag == ZERO_TAG) begin
            op.ready = 1'b1;
        end else if (!src.ready && bus.valid && bus.tag == src.tag) begin
            op.value = bus.value;
            op.ready = 1'b1;
        end
        return op;
    endfunction

    always_comb begin
        new_entry.op = dispatch.op;
        new_entry.dest = dispatch.dest;
        for (int s = 0; s < 2; s++) begin
            new_entry.src[s] = capture(dispatch.src[s], cdb);
        end
    end

    // an entry granted this cycle is freed at the same edge
    assign free = ~busy | grant;

    always_comb begin
        found = 1'b0;
        new_idx = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (free[i] && !found) begin
                found = 1'b1;
                new_idx = entry_idx_t'(i);
            end
        end
    end

    assign new_valid = dispatch.valid && found;

    // chosen entry is occupied after the write edge, unless squash emptied the array
    a_idx_written: assert property (
        @(posedge clock) disable iff (reset)
        new_valid |=> (busy[$past(new_idx)] || (busy == '0))
    ) else $error("dispatched entry was not written");

endmodule

// ==== logic/rs_entry_array.sv ====
//////////////////////////////////////////////////////////////////////
// entry storage and busy bits
// CDB wakeup, freeing on grant, squash and the full flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_entry_array (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           squash,
    input  logic                           new_valid,
    input  rs_bus_pkg::rs_entry_t          new_entry,
    input  rs_types_pkg::entry_idx_t       new_idx,
    input  rs_bus_pkg::cdb_packet_t        cdb,
    input  rs_types_pkg::entry_mask_t      grant,
    output rs_bus_pkg::rs_entry_t [rs_types_pkg::NUM_ENTRIES-1:0] entries,
    output rs_types_pkg::entry_mask_t      busy,
    output logic                           full
);

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    rs_entry_t [NUM_ENTRIES-1:0] next_entries;
    entry_mask_t                 next_busy;

    always_comb begin
        next_entries = entries;
        next_busy = busy & ~grant;

        // wakeup of waiting operands
        if (cdb.valid) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                for (int s = 0; s < 2; s++) begin
                    if (busy[i] && !entries[i].src[s].ready &&
                        entries[i].src[s].tag == cdb.tag) begin
                        next_entries[i].src[s].value = cdb.value;
                        next_entries[i].src[s].ready = 1'b1;
                    end
                end
            end
        end

        // new entry already carries the bypassed operands
        if (new_valid) begin
            next_entries[new_idx] = new_entry;
            next_busy[new_idx] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
        end else begin
            busy <= next_busy;
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

    // a grant this cycle frees an entry at the edge
    assign full = (&busy) && !(|grant);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_no_dispatch_full: assert property (
        @(posedge clock) disable iff (reset)
        full |-> !new_valid
    ) else $error("dispatch accepted while full");

    a_grant_busy: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(grant) && ((grant & ~busy) == '0)
    ) else $error("grant not one-hot or names an idle entry");

endmodule

// ==== logic/alu_unit.sv ====
//////////////////////////////////////////////////////////////////////
// per-entry integer ALU
// computes once when operands are ready, holds the result until granted
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  rs_bus_pkg::rs_entry_t    entry,
    input  logic                     busy,
    input  logic                     granted,
    output logic                     result_valid,
    output rs_types_pkg::data_t      result
);

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    data_t a;
    data_t b;
    data_t alu_out;
    logic  done;
    logic  fire;

    assign a = entry.src[0].value;
    assign b = entry.src[1].value;

    always_comb begin
        case (entry.op)
            ALU_ADD: alu_out = a + b;
            ALU_SUB: alu_out = a - b;
            ALU_AND: alu_out = a & b;
            ALU_OR:  alu_out = a | b;
            ALU_XOR: alu_out = a ^ b;
            ALU_SLL: alu_out = a << b[SHAMT_WIDTH-1:0];
            ALU_SRL: alu_out = a >> b[SHAMT_WIDTH-1:0];
            ALU_SLT: alu_out = ($signed(a) < $signed(b)) ? data_t'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    assign fire = busy && entry.src[0].ready && entry.src[1].ready &&
                  !result_valid && !done;

    // granted entry may be refilled at the same edge, so clear done there too
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result_valid <= 1'b0;
            done <= 1'b0;
        end else if (granted) begin
            result_valid <= 1'b0;
            done <= 1'b0;
        end else if (!busy) begin
            done <= 1'b0;
        end else if (fire) begin
            result_valid <= 1'b1;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            result <= alu_out;
        end
    end

endmodule

// ==== logic/cdb_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// fixed-priority CDB arbiter
// lowest-index held result wins the broadcast
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cdb_arbiter (
    input  rs_types_pkg::entry_mask_t                              result_valid,
    input  rs_types_pkg::data_t [rs_types_pkg::NUM_ENTRIES-1:0]    results,
    input  rs_bus_pkg::rs_entry_t [rs_types_pkg::NUM_ENTRIES-1:0]  entries,
    output rs_types_pkg::entry_mask_t                              grant,
    output rs_bus_pkg::cdb_packet_t                                cdb
);

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    // scan from the top so the lowest index overrides
    always_comb begin
        grant = '0;
        cdb = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (result_valid[i]) begin
                grant = '0;
                grant[i] = 1'b1;
                cdb.valid = 1'b1;
                cdb.tag = entries[i].dest;
                cdb.value = results[i];
            end
        end
    end

endmodule

// ==== logic/rs_top.sv ====
//////////////////////////////////////////////////////////////////////
// reservation station top
// dispatch, entry array, per-entry ALUs and the CDB arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           squash,
    input  rs_bus_pkg::dispatch_packet_t   dispatch,
    output rs_bus_pkg::cdb_packet_t        cdb,
    output logic                           full
);

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    rs_entry_t                   new_entry;
    logic                        new_valid;
    entry_idx_t                  new_idx;
    rs_entry_t [NUM_ENTRIES-1:0] entries;
    entry_mask_t                 busy;
    entry_mask_t                 grant;
    entry_mask_t                 result_valid;
    data_t [NUM_ENTRIES-1:0]     results;

    rs_dispatch u_dispatch (
        .clock     (clock),
        .reset     (reset),
        .dispatch  (dispatch),
        .cdb       (cdb),
        .busy      (busy),
        .grant     (grant),
        .new_entry (new_entry),
        .new_valid (new_valid),
        .new_idx   (new_idx)
    );

    rs_entry_array u_entry_array (
        .clock     (clock),
        .reset     (reset),
        .squash    (squash),
        .new_valid (new_valid),
        .new_entry (new_entry),
        .new_idx   (new_idx),
        .cdb       (cdb),
        .grant     (grant),
        .entries   (entries),
        .busy      (busy),
        .full      (full)
    );

    // one ALU per entry
    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_alu
        alu_unit u_alu (
            .clock        (clock),
            .reset        (reset),
            .squash       (squash),
            .entry        (entries[i]),
            .busy         (busy[i]),
            .granted      (grant[i]),
            .result_valid (result_valid[i]),
            .result       (results[i])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .result_valid (result_valid),
        .results      (results),
        .entries      (entries),
        .grant        (grant),
        .cdb          (cdb)
    );

endmodule

// ==== dv/rs_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the reservation station top
// clock, reset, LCG, reference model and directed tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_tb;

    import rs_types_pkg::*;
    import rs_bus_pkg::*;

    logic             clock;
    logic             reset;
    logic             squash;
    dispatch_packet_t dispatch;
    cdb_packet_t      cdb;
    logic             full;

    // model state indexed by dest tag
    logic             in_flight [2**TAG_WIDTH];
    data_t            exp_value [2**TAG_WIDTH];
    int               pending;
    int unsigned      lcg_state;

    rs_top UUT (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .full     (full)
    );

    always #5 clock = ~clock;

    task automatic check_value(input data_t actual, input data_t expected, input string msg);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
            $display("Errors found");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Errors found");
        $fatal(1, "wait loop ran out of cycles");
    endtask

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // every broadcast must retire a tag that is in flight
    task automatic observe_cdb();
        if (cdb.valid) begin
            check_value(data_t'(in_flight[cdb.tag]), 32'd1,
                        $sformatf("tag %0d broadcast while not in flight", cdb.tag));
            check_value(cdb.value, exp_value[cdb.tag],
                        $sformatf("value broadcast for tag %0d", cdb.tag));
            in_flight[cdb.tag] = 1'b0;
            pending--;
        end
    endtask

    // one cycle, broadcast sampled at the falling edge
    task automatic step();
        @(negedge clock);
        observe_cdb();
        @(posedge clock);
        #1;
    endtask

    function automatic tag_t pick_in_flight(input tag_t start);
        tag_t t;
        for (int k = 0; k < 2**TAG_WIDTH; k++) begin
            t = tag_t'(int'(start) + k);
            if (t != ZERO_TAG && in_flight[t]) begin
                return t;
            end
        end
        return ZERO_TAG;
    endfunction

    function automatic tag_t pick_free_tag(input tag_t start);
        tag_t t;
        for (int k = 0; k < 2**TAG_WIDTH; k++) begin
            t = tag_t'(int'(start) + k);
            if (t != ZERO_TAG && !in_flight[t]) begin
                return t;
            end
        end
        return ZERO_TAG;
    endfunction

    task automatic dispatch_op(input alu_op_e op, input tag_t tag0, input data_t val0,
                               input tag_t tag1, input data_t val1, input tag_t dest);
        tag_t             tags [2];
        data_t            vals [2];
        data_t            operand [2];
        dispatch_packet_t pkt;
        int               count;
        tags[0] = tag0;
        tags[1] = tag1;
        vals[0] = val0;
        vals[1] = val1;
        count = 0;
        while (full && count < 200) begin
            step();
            count++;
        end
        if (full) begin
            report_timeout("full stayed high and the dispatch was never taken");
        end
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.op = op;
        pkt.dest = dest;
        for (int s = 0; s < 2; s++) begin
            if (tags[s] != ZERO_TAG && in_flight[tags[s]]) begin
                // producer still pending
                pkt.src[s].tag = tags[s];
                pkt.src[s].value = 32'hdead_beef;
                operand[s] = exp_value[tags[s]];
            end else begin
                // retired producer acts like a register file read
                operand[s] = (tags[s] == ZERO_TAG) ? vals[s] : exp_value[tags[s]];
                pkt.src[s].value = operand[s];
                pkt.src[s].ready = 1'b1;
            end
        end
        exp_value[dest] = alu_model(op, operand[0], operand[1]);
        in_flight[dest] = 1'b1;
        pending++;
        dispatch = pkt;
        step();
        dispatch.valid = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int count;
        count = 0;
        while (pending != 0 && count < limit) begin
            step();
            count++;
        end
        if (pending != 0) begin
            report_timeout($sformatf("%0d results were never broadcast", pending));
        end
    endtask

    task automatic wait_for_tag(input tag_t tag, input int limit);
        int count;
        count = 0;
        while (!(cdb.valid && cdb.tag == tag) && count < limit) begin
            step();
            count++;
        end
        if (!(cdb.valid && cdb.tag == tag)) begin
            report_timeout($sformatf("tag %0d never appeared on the CDB", tag));
        end
    endtask

    task automatic hold_on_tag(input tag_t dest, input tag_t wait_tag);
        dispatch_packet_t pkt;
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.op = ALU_ADD;
        pkt.src[0].tag = wait_tag;
        pkt.src[1].value = 32'd1;
        pkt.src[1].ready = 1'b1;
        pkt.dest = dest;
        dispatch = pkt;
        step();
        dispatch.valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic after_reset_idle();
        check_value(data_t'(cdb.valid), 32'd0, "cdb valid after reset");
        check_value(data_t'(full), 32'd0, "full after reset");
    endtask

    task automatic each_op_once();
        for (int i = 0; i < 8; i++) begin
            dispatch_op(alu_op_e'(i), ZERO_TAG, 32'hf0f0_1234, ZERO_TAG,
                        data_t'(32'h0000_0123 + i), tag_t'(i + 1));
        end
        wait_idle(100);
    endtask

    task automatic dependent_chain();
        dispatch_op(ALU_ADD, ZERO_TAG, 32'd5, ZERO_TAG, 32'd7, tag_t'(9));
        dispatch_op(ALU_SUB, tag_t'(9), 32'd0, ZERO_TAG, 32'd3, tag_t'(10));
        dispatch_op(ALU_SLL, tag_t'(10), 32'd0, ZERO_TAG, 32'd4, tag_t'(11));
        wait_idle(50);
    endtask

    // consumer presented in the very cycle its producer broadcasts
    task automatic cdb_bypass();
        dispatch_op(ALU_XOR, ZERO_TAG, 32'h1234_5678, ZERO_TAG, 32'h0f0f_0f0f, tag_t'(12));
        wait_for_tag(tag_t'(12), 20);
        dispatch_op(ALU_ADD, tag_t'(12), 32'd0, ZERO_TAG, 32'd1, tag_t'(13));
        wait_idle(50);
    endtask

    task automatic full_then_squash();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hold_on_tag(tag_t'(20 + i), tag_t'(31));
        end
        check_value(data_t'(full), 32'd1, "full with every entry waiting");
        squash = 1'b1;
        step();
        squash = 1'b0;
        check_value(data_t'(full), 32'd0, "full after squash");
        check_value(data_t'(cdb.valid), 32'd0, "cdb valid after squash");
        // broadcasting the awaited tag wakes any entry that survived
        dispatch_op(ALU_OR, ZERO_TAG, 32'h0000_00a5, ZERO_TAG, 32'h0000_5a00, tag_t'(31));
        wait_idle(20);
        // squashed tags never entered the model
        repeat (20) step();
    endtask

    task automatic random_stream(input int count);
        int unsigned r;
        alu_op_e     op;
        tag_t        src_tag [2];
        data_t       src_val [2];
        tag_t        dest;
        for (int n = 0; n < count; n++) begin
            r = next_rand();
            op = alu_op_e'(r[30:28]);
            for (int s = 0; s < 2; s++) begin
                r = next_rand();
                src_val[s] = r;
                src_tag[s] = ZERO_TAG;
                if (r[31] && pending > 0) begin
                    src_tag[s] = pick_in_flight(r[29:25]);
                end
            end
            r = next_rand();
            dest = pick_free_tag(r[29:25]);
            dispatch_op(op, src_tag[0], src_val[0], src_tag[1], src_val[1], dest);
            if (r[31:30] == 2'd0) begin
                step();
            end
        end
        wait_idle(300);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        squash = 1'b0;
        dispatch = '0;
        pending = 0;
        lcg_state = 4;
        for (int t = 0; t < 2**TAG_WIDTH; t++) begin
            in_flight[t] = 1'b0;
            exp_value[t] = '0;
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        after_reset_idle();
        each_op_once();
        dependent_chain();
        cdb_bypass();
        full_then_squash();
        random_stream(60);

        $display("No errors");
        $finish;
    end

endmodule

// ==== src.f ====
logic/rs_types_pkg.sv
logic/rs_bus_pkg.sv
logic/rs_dispatch.sv
logic/rs_entry_array.sv
logic/alu_unit.sv
logic/cdb_arbiter.sv
logic/rs_top.sv
dv/rs_tb.sv

// ==== Makefile ====
# Verilator build and run for the reservation station testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rs_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the pass line in the log decides the result
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
